/* design/vx_cfg.svh */
`ifndef VX_CFG_SVH
`define VX_CFG_SVH

// Thread lanes per warp
`define NT 4

// Warps sharing the pipeline
`define NW 4
`define NW_BITS 2

// Architectural registers per lane
`define NR 32
`define REG_BITS 5

// Data path width
`define XLEN 32

`endif

/* design/vx_isa_pkg.sv */
package vx_isa_pkg;

	// Major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_ALUI   = 7'b0010011;
	localparam logic [6:0] OPC_ALU    = 7'b0110011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD   = 3'b000;
	localparam logic [2:0] F3_XOR   = 3'b100;
	localparam logic [2:0] F3_OR    = 3'b110;
	localparam logic [2:0] F3_AND   = 3'b111;
	localparam logic [2:0] F3_WORD  = 3'b010;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [6:0] F7_SUB   = 7'b0100000;

	// Memory port idle code
	localparam logic [2:0] MEM_NONE = 3'b111;

	localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

	// Read-only CSRs
	localparam logic [11:0] CSR_LANE_ID = 12'h020;
	localparam logic [11:0] CSR_WARP_ID = 12'h021;
	localparam logic [11:0] CSR_GTID    = 12'h022;
	localparam logic [11:0] CSR_CYCLE   = 12'hC00;

	typedef enum logic [3:0] {
		OP_NOP, OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_AND,
		OP_OR, OP_XOR, OP_LW, OP_SW, OP_CSRR
	} op_e;

endpackage

/* design/vx_pipe_pkg.sv */
`include "vx_cfg.svh"

package vx_pipe_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef word_t [`NT-1:0] lane_words_t;

	typedef struct packed {
		logic                 valid;
		logic [`NW_BITS-1:0]  warp_num;
		vx_isa_pkg::op_e      op;
		logic [`REG_BITS-1:0] rd;
		word_t                imm;
		logic [11:0]          csr_address;
		lane_words_t          rs1_data;
		lane_words_t          rs2_data;
	} de_t;

	typedef struct packed {
		logic                 valid;
		logic [`NW_BITS-1:0]  warp_num;
		logic [`REG_BITS-1:0] rd;
		logic                 wb_en;
		logic                 is_load;
		logic [2:0]           mem_read;
		logic [2:0]           mem_write;
		lane_words_t          result;
		lane_words_t          store_data;
	} em_t;

	typedef struct packed {
		logic                 valid;
		logic [`NW_BITS-1:0]  warp_num;
		logic [`REG_BITS-1:0] rd;
		logic                 wb_en;
		lane_words_t          data;
	} mw_t;

endpackage

/* design/vx_pipe_reg.sv */
`timescale 1ns/1ps

module vx_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t d,
	output payload_t q
);

	// Whole payload cleared so valid bits start low
	always_ff @(posedge clk) begin
		if (!rst_n)
			q <= '0;
		else
			q <= d;
	end

endmodule

/* design/vx_fetch.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_fetch (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [31:0]         icache_response_instruction,
	output logic [31:0]         icache_request_pc_address,
	output logic                fetch_valid,
	output logic [`NW_BITS-1:0] fetch_warp_num,
	output logic [31:0]         fetch_instruction,
	output logic                out_ebreak
);
	import vx_isa_pkg::*;

	logic [31:0]         pc [`NW];
	logic [`NW-1:0]      active;
	logic [`NW-1:0]      retire_mask;
	logic [`NW_BITS-1:0] last_warp;
	logic [`NW_BITS-1:0] next_warp;
	logic                issue;
	logic                is_ebreak;

	// Nearest active warp after the last one issued
	always_comb begin
		logic [`NW_BITS-1:0] cand;
		next_warp = last_warp;
		issue     = 1'b0;
		for (int i = `NW; i >= 1; i--) begin
			cand = last_warp + `NW_BITS'(i);
			if (active[cand]) begin
				next_warp = cand;
				issue     = 1'b1;
			end
		end
	end

	assign icache_request_pc_address = pc[next_warp];
	assign is_ebreak   = issue && (icache_response_instruction == EBREAK_INST);
	assign retire_mask = is_ebreak ? (`NW'(1) << next_warp) : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active      <= '1;
			last_warp   <= '1;
			fetch_valid <= 1'b0;
			out_ebreak  <= 1'b0;
			for (int w = 0; w < `NW; w++) begin
				pc[w] <= '0;
			end
		end else begin
			fetch_valid <= issue && !is_ebreak;
			active      <= active & ~retire_mask;
			if (issue) begin
				last_warp <= next_warp;
				// Retired warp keeps its PC
				if (!is_ebreak)
					pc[next_warp] <= pc[next_warp] + 32'd4;
			end
			if ((active & ~retire_mask) == '0)
				out_ebreak <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		fetch_warp_num    <= next_warp;
		fetch_instruction <= icache_response_instruction;
	end

endmodule

/* design/vx_front_end.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_front_end (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     fetch_valid,
	input  logic [`NW_BITS-1:0]      fetch_warp_num,
	input  logic [31:0]              fetch_instruction,
	input  vx_pipe_pkg::lane_words_t fwd_rs1_data,
	input  vx_pipe_pkg::lane_words_t fwd_rs2_data,
	input  logic                     fwd_rs1_hit,
	input  logic                     fwd_rs2_hit,
	input  vx_pipe_pkg::mw_t         wb,
	output logic [`NW_BITS-1:0]      req_warp_num,
	output logic [4:0]               req_rs1,
	output logic [4:0]               req_rs2,
	output vx_pipe_pkg::de_t         de
);
	import vx_isa_pkg::*;
	import vx_pipe_pkg::*;

	logic [`XLEN-1:0] regs [`NW][`NT][`NR];

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_e        dec_op;
	word_t      dec_imm;
	de_t        de_next;
	de_t        de_q;
	logic       de_valid_q;

	assign opcode       = fetch_instruction[6:0];
	assign funct3       = fetch_instruction[14:12];
	assign funct7       = fetch_instruction[31:25];
	assign req_warp_num = fetch_warp_num;
	assign req_rs1      = fetch_instruction[19:15];
	assign req_rs2      = fetch_instruction[24:20];

	always_comb begin
		dec_op  = OP_NOP;
		dec_imm = {{20{fetch_instruction[31]}}, fetch_instruction[31:20]};
		case (opcode)
			OPC_LUI: begin
				dec_op  = OP_LUI;
				dec_imm = {fetch_instruction[31:12], 12'b0};
			end
			OPC_ALUI: if (funct3 == F3_ADD) dec_op = OP_ADDI;
			OPC_ALU: begin
				case (funct3)
					F3_ADD:  dec_op = (funct7 == F7_SUB) ? OP_SUB : OP_ADD;
					F3_AND:  dec_op = OP_AND;
					F3_OR:   dec_op = OP_OR;
					F3_XOR:  dec_op = OP_XOR;
					default: dec_op = OP_NOP;
				endcase
			end
			OPC_LOAD: if (funct3 == F3_WORD) dec_op = OP_LW;
			OPC_STORE: begin
				if (funct3 == F3_WORD) dec_op = OP_SW;
				dec_imm = {{20{fetch_instruction[31]}}, fetch_instruction[31:25],
					fetch_instruction[11:7]};
			end
			OPC_SYSTEM: if (funct3 == F3_CSRRS) dec_op = OP_CSRR;
			default: dec_op = OP_NOP;
		endcase
	end

	// Operand read, forwarded value wins
	always_comb begin
		de_next.valid       = fetch_valid && (dec_op != OP_NOP);
		de_next.warp_num    = fetch_warp_num;
		de_next.op          = dec_op;
		de_next.rd          = fetch_instruction[11:7];
		de_next.imm         = dec_imm;
		de_next.csr_address = fetch_instruction[31:20];
		for (int l = 0; l < `NT; l++) begin
			if (req_rs1 == '0)
				de_next.rs1_data[l] = '0;
			else
				de_next.rs1_data[l] = fwd_rs1_hit ? fwd_rs1_data[l] : regs[fetch_warp_num][l][req_rs1];
			if (req_rs2 == '0)
				de_next.rs2_data[l] = '0;
			else
				de_next.rs2_data[l] = fwd_rs2_hit ? fwd_rs2_data[l] : regs[fetch_warp_num][l][req_rs2];
		end
	end

	// Writeback port, x0 stays zero
	always_ff @(posedge clk) begin
		if (wb.valid && wb.wb_en && (wb.rd != '0)) begin
			for (int l = 0; l < `NT; l++) begin
				regs[wb.warp_num][l][wb.rd] <= wb.data[l];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			de_valid_q <= 1'b0;
		else
			de_valid_q <= de_next.valid;
	end

	always_ff @(posedge clk) begin
		de_q <= de_next;
	end

	always_comb begin
		de       = de_q;
		de.valid = de_valid_q;
	end

endmodule

/* design/vx_forwarding.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_forwarding (
	input  logic [`NW_BITS-1:0]      req_warp_num,
	input  logic [4:0]               req_rs1,
	input  logic [4:0]               req_rs2,
	input  vx_pipe_pkg::em_t         exe,
	input  vx_pipe_pkg::mw_t         mem,
	input  vx_pipe_pkg::mw_t         wb,
	output vx_pipe_pkg::lane_words_t fwd_rs1_data,
	output vx_pipe_pkg::lane_words_t fwd_rs2_data,
	output logic                     fwd_rs1_hit,
	output logic                     fwd_rs2_hit
);
	import vx_pipe_pkg::*;

	function automatic logic hits(input logic valid, input logic wb_en,
			input logic [`NW_BITS-1:0] warp, input logic [4:0] rd, input logic [4:0] rs);
		return valid && wb_en && (warp == req_warp_num) && (rd == rs) && (rd != 5'd0);
	endfunction

	// Youngest producer first
	function automatic logic pick(input logic [4:0] rs, output lane_words_t data);
		pick = 1'b1;
		if (hits(exe.valid, exe.wb_en, exe.warp_num, exe.rd, rs))
			data = exe.result;
		else if (hits(mem.valid, mem.wb_en, mem.warp_num, mem.rd, rs))
			data = mem.data;
		else if (hits(wb.valid, wb.wb_en, wb.warp_num, wb.rd, rs))
			data = wb.data;
		else begin
			data = '0;
			pick = 1'b0;
		end
	endfunction

	always_comb begin
		fwd_rs1_hit = pick(req_rs1, fwd_rs1_data);
		fwd_rs2_hit = pick(req_rs2, fwd_rs2_data);
	end

endmodule

/* design/vx_execute.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_execute (
	input  vx_pipe_pkg::de_t         de,
	input  vx_pipe_pkg::lane_words_t csr_data,
	output logic [11:0]              csr_address,
	output logic [`NW_BITS-1:0]      csr_warp_num,
	output vx_pipe_pkg::em_t         em
);
	import vx_isa_pkg::*;

	assign csr_address  = de.csr_address;
	assign csr_warp_num = de.warp_num;

	always_comb begin
		em.valid     = de.valid;
		em.warp_num  = de.warp_num;
		em.rd        = de.rd;
		em.wb_en     = de.valid && (de.op != OP_SW) && (de.op != OP_NOP);
		em.is_load   = de.valid && (de.op == OP_LW);
		em.mem_read  = (de.valid && de.op == OP_LW) ? F3_WORD : MEM_NONE;
		em.mem_write = (de.valid && de.op == OP_SW) ? F3_WORD : MEM_NONE;
		for (int l = 0; l < `NT; l++) begin
			case (de.op)
				OP_LUI:                em.result[l] = de.imm;
				// Loads and stores share the address adder
				OP_ADDI, OP_LW, OP_SW: em.result[l] = de.rs1_data[l] + de.imm;
				OP_ADD:                em.result[l] = de.rs1_data[l] + de.rs2_data[l];
				OP_SUB:                em.result[l] = de.rs1_data[l] - de.rs2_data[l];
				OP_AND:                em.result[l] = de.rs1_data[l] & de.rs2_data[l];
				OP_OR:                 em.result[l] = de.rs1_data[l] | de.rs2_data[l];
				OP_XOR:                em.result[l] = de.rs1_data[l] ^ de.rs2_data[l];
				OP_CSRR:               em.result[l] = csr_data[l];
				default:               em.result[l] = '0;
			endcase
			em.store_data[l] = de.rs2_data[l];
		end
	end

endmodule

/* design/vx_csr_handler.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_csr_handler (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [11:0]              csr_address,
	input  logic [`NW_BITS-1:0]      csr_warp_num,
	output vx_pipe_pkg::lane_words_t csr_data
);
	import vx_isa_pkg::*;

	logic [31:0] cycle_count;

	always_ff @(posedge clk) begin
		if (!rst_n)
			cycle_count <= '0;
		else
			cycle_count <= cycle_count + 32'd1;
	end

	always_comb begin
		for (int l = 0; l < `NT; l++) begin
			case (csr_address)
				CSR_LANE_ID: csr_data[l] = 32'(l);
				CSR_WARP_ID: csr_data[l] = 32'(csr_warp_num);
				CSR_GTID:    csr_data[l] = 32'(csr_warp_num) * 32'(`NT) + 32'(l);
				CSR_CYCLE:   csr_data[l] = cycle_count;
				default:     csr_data[l] = '0;
			endcase
		end
	end

endmodule

/* design/vx_core.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_core (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] icache_response_instruction,
	output logic [31:0] icache_request_pc_address,
	input  logic [31:0] in_cache_driver_out_data [`NT-1:0],
	output logic [31:0] out_cache_driver_in_address [`NT-1:0],
	output logic [2:0]  out_cache_driver_in_mem_read,
	output logic [2:0]  out_cache_driver_in_mem_write,
	output logic        out_cache_driver_in_valid [`NT-1:0],
	output logic [31:0] out_cache_driver_in_data [`NT-1:0],
	output logic        out_ebreak
);
	import vx_isa_pkg::*;
	import vx_pipe_pkg::*;

	logic                fetch_valid;
	logic [`NW_BITS-1:0] fetch_warp_num;
	logic [31:0]         fetch_instruction;
	logic [`NW_BITS-1:0] req_warp_num;
	logic [4:0]          req_rs1;
	logic [4:0]          req_rs2;
	lane_words_t         fwd_rs1_data;
	lane_words_t         fwd_rs2_data;
	logic                fwd_rs1_hit;
	logic                fwd_rs2_hit;
	logic [11:0]         csr_address;
	logic [`NW_BITS-1:0] csr_warp_num;
	lane_words_t         csr_data;
	lane_words_t         load_data;
	logic                mem_active;
	de_t                 de;
	em_t                 em;
	em_t                 mem_stage;
	mw_t                 mem_wb;
	mw_t                 wb;

	vx_fetch vx_fetch (
		.clk                        (clk),
		.rst_n                      (rst_n),
		.icache_response_instruction(icache_response_instruction),
		.icache_request_pc_address  (icache_request_pc_address),
		.fetch_valid                (fetch_valid),
		.fetch_warp_num             (fetch_warp_num),
		.fetch_instruction          (fetch_instruction),
		.out_ebreak                 (out_ebreak)
	);

	vx_front_end vx_front_end (
		.clk              (clk),
		.rst_n            (rst_n),
		.fetch_valid      (fetch_valid),
		.fetch_warp_num   (fetch_warp_num),
		.fetch_instruction(fetch_instruction),
		.fwd_rs1_data     (fwd_rs1_data),
		.fwd_rs2_data     (fwd_rs2_data),
		.fwd_rs1_hit      (fwd_rs1_hit),
		.fwd_rs2_hit      (fwd_rs2_hit),
		.wb               (wb),
		.req_warp_num     (req_warp_num),
		.req_rs1          (req_rs1),
		.req_rs2          (req_rs2),
		.de               (de)
	);

	vx_forwarding vx_forwarding (
		.req_warp_num(req_warp_num),
		.req_rs1     (req_rs1),
		.req_rs2     (req_rs2),
		.exe         (em),
		.mem         (mem_wb),
		.wb          (wb),
		.fwd_rs1_data(fwd_rs1_data),
		.fwd_rs2_data(fwd_rs2_data),
		.fwd_rs1_hit (fwd_rs1_hit),
		.fwd_rs2_hit (fwd_rs2_hit)
	);

	vx_execute vx_execute (
		.de          (de),
		.csr_data    (csr_data),
		.csr_address (csr_address),
		.csr_warp_num(csr_warp_num),
		.em          (em)
	);

	vx_csr_handler vx_csr_handler (
		.clk         (clk),
		.rst_n       (rst_n),
		.csr_address (csr_address),
		.csr_warp_num(csr_warp_num),
		.csr_data    (csr_data)
	);

	vx_pipe_reg #(.payload_t(em_t)) e_m_reg (
		.clk  (clk),
		.rst_n(rst_n),
		.d    (em),
		.q    (mem_stage)
	);

	// Data port driven straight from the e_m register
	assign mem_active = mem_stage.valid &&
		((mem_stage.mem_read != MEM_NONE) || (mem_stage.mem_write != MEM_NONE));
	assign out_cache_driver_in_mem_read  = mem_stage.valid ? mem_stage.mem_read : MEM_NONE;
	assign out_cache_driver_in_mem_write = mem_stage.valid ? mem_stage.mem_write : MEM_NONE;

	always_comb begin
		for (int l = 0; l < `NT; l++) begin
			load_data[l]                   = in_cache_driver_out_data[l];
			out_cache_driver_in_address[l] = mem_stage.result[l];
			out_cache_driver_in_data[l]    = mem_stage.store_data[l];
			out_cache_driver_in_valid[l]   = mem_active;
		end
	end

	always_comb begin
		mem_wb.valid    = mem_stage.valid;
		mem_wb.warp_num = mem_stage.warp_num;
		mem_wb.rd       = mem_stage.rd;
		mem_wb.wb_en    = mem_stage.wb_en;
		mem_wb.data     = mem_stage.is_load ? load_data : mem_stage.result;
	end

	vx_pipe_reg #(.payload_t(mw_t)) m_w_reg (
		.clk  (clk),
		.rst_n(rst_n),
		.d    (mem_wb),
		.q    (wb)
	);

endmodule

/* tests/vx_core_assert.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module vx_core_assert (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] icache_request_pc_address,
	input logic [31:0] out_cache_driver_in_address [`NT-1:0],
	input logic [2:0]  out_cache_driver_in_mem_read,
	input logic [2:0]  out_cache_driver_in_mem_write,
	input logic        out_cache_driver_in_valid [`NT-1:0],
	input logic [31:0] out_cache_driver_in_data [`NT-1:0],
	input logic        out_ebreak
);
	import vx_isa_pkg::*;

	int unsigned fail_count = 0;
	int unsigned fetch_slot;
	logic [31:0] expected_pc;
	logic        reading;
	logic        writing;

	assign reading = out_cache_driver_in_mem_read != MEM_NONE;
	assign writing = out_cache_driver_in_mem_write != MEM_NONE;

	always_ff @(posedge clk) begin
		if (!rst_n)
			fetch_slot <= 0;
		else
			fetch_slot <= fetch_slot + 1;
	end

	// Warps start together, one PC step per round, EBREAK sits at 32
	assign expected_pc = (fetch_slot < 32'd8 * `NW) ?
		32'(fetch_slot / `NW) * 32'd4 : 32'd32;

	pc_sequence: assert property (@(negedge clk)
			rst_n |-> icache_request_pc_address == expected_pc)
		else begin
			fail_count++;
			$error("CHECK FAILED t=%0t icache_request_pc_address got %h expected %h",
				$time, icache_request_pc_address, expected_pc);
		end

	// Data port comes from the e_m register, settled by the falling edge
	idle_read: assert property (@(negedge clk)
			(!rst_n || !$past(rst_n)) |-> !reading)
		else begin
			fail_count++;
			$error("CHECK FAILED t=%0t out_cache_driver_in_mem_read got %h expected %h",
				$time, out_cache_driver_in_mem_read, MEM_NONE);
		end

	idle_write: assert property (@(negedge clk)
			(!rst_n || !$past(rst_n) || reading) |-> !writing)
		else begin
			fail_count++;
			$error("CHECK FAILED t=%0t out_cache_driver_in_mem_write got %h expected %h",
				$time, out_cache_driver_in_mem_write, MEM_NONE);
		end

	ebreak_holds: assert property (@(negedge clk) (rst_n && out_ebreak) |=> out_ebreak)
		else begin
			fail_count++;
			$error("CHECK FAILED t=%0t out_ebreak got %b expected 1", $time, out_ebreak);
		end

	for (genvar l = 0; l < `NT; l++) begin : g_lane
		valid_match: assert property (@(negedge clk)
				out_cache_driver_in_valid[l] == (reading || writing))
			else begin
				fail_count++;
				$error("CHECK FAILED t=%0t out_cache_driver_in_valid[%0d] got %b expected %b",
					$time, l, out_cache_driver_in_valid[l], reading || writing);
			end

		// Lower half holds gid + 100
		low_store: assert property (@(negedge clk)
				(writing && out_cache_driver_in_address[l] < 32'd256) |->
				out_cache_driver_in_data[l] == out_cache_driver_in_address[l] / 32'd4 + 32'd100)
			else begin
				fail_count++;
				$error("CHECK FAILED t=%0t out_cache_driver_in_data[%0d] got %0d expected %0d",
					$time, l, out_cache_driver_in_data[l],
					out_cache_driver_in_address[l] / 32'd4 + 32'd100);
			end

		// Upper half holds twice the loaded value
		high_store: assert property (@(negedge clk)
				(writing && out_cache_driver_in_address[l] >= 32'd256) |->
				out_cache_driver_in_data[l] ==
				32'd2 * ((out_cache_driver_in_address[l] - 32'd256) / 32'd4 + 32'd100))
			else begin
				fail_count++;
				$error("CHECK FAILED t=%0t out_cache_driver_in_data[%0d] got %0d expected %0d",
					$time, l, out_cache_driver_in_data[l],
					32'd2 * ((out_cache_driver_in_address[l] - 32'd256) / 32'd4 + 32'd100));
			end
	end

endmodule

/* tests/tb_vx_core.sv */
`timescale 1ns/1ps
`include "vx_cfg.svh"

module tb_vx_core;
	import vx_isa_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int STORES_EXPECTED = 2 * `NW * `NT;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic [31:0] icache_response_instruction = '0;
	logic [31:0] icache_request_pc_address;
	logic [31:0] in_cache_driver_out_data [`NT-1:0] = '{default: '0};
	logic [31:0] out_cache_driver_in_address [`NT-1:0];
	logic [2:0]  out_cache_driver_in_mem_read;
	logic [2:0]  out_cache_driver_in_mem_write;
	logic        out_cache_driver_in_valid [`NT-1:0];
	logic [31:0] out_cache_driver_in_data [`NT-1:0];
	logic        out_ebreak;

	logic [31:0] rom [16];
	logic [31:0] dmem [128];
	int          errors;
	int          store_count = 0;

	vx_core dut0 (.*);

	bind vx_core vx_core_assert checks (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] rtype_add(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Instruction and load data follow the addresses from the last rising edge
	always @(negedge clk) begin
		icache_response_instruction = rom[icache_request_pc_address[5:2]];
		for (int l = 0; l < `NT; l++)
			in_cache_driver_out_data[l] = dmem[out_cache_driver_in_address[l][8:2]];
	end

	always @(posedge clk) begin
		if (out_cache_driver_in_mem_write != MEM_NONE) begin
			for (int l = 0; l < `NT; l++) begin
				if (out_cache_driver_in_valid[l]) begin
					dmem[out_cache_driver_in_address[l][8:2]] = out_cache_driver_in_data[l];
					store_count++;
				end
			end
		end
	end

	initial begin
		logic [31:0] seed;
		int          cycles;
		int          assert_fails;
		errors = 0;

		// Unused slots hold EBREAK
		for (int i = 0; i < 16; i++)
			rom[i] = 32'h0010_0073;
		rom[0] = itype_word(12'h022, 5'd0, 3'b010, 5'd1, 7'b1110011);
		rom[1] = rtype_add(5'd2, 5'd1, 5'd1);
		rom[2] = rtype_add(5'd2, 5'd2, 5'd2);
		rom[3] = itype_word(12'd100, 5'd1, 3'b000, 5'd3, 7'b0010011);
		rom[4] = store_word(12'd0, 5'd3, 5'd2);
		rom[5] = itype_word(12'd0, 5'd2, 3'b010, 5'd5, 7'b0000011);
		rom[6] = rtype_add(5'd6, 5'd5, 5'd5);
		rom[7] = store_word(12'd256, 5'd6, 5'd2);

		seed = 32'h40f8_40b4;
		for (int i = 0; i < 128; i++) begin
			seed = next_random(seed);
			dmem[i] = seed;
		end

		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		cycles = 0;
		while (!out_ebreak && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end

		if (!out_ebreak) begin
			$display("Timeout: out_ebreak still low after %0d cycles", TIMEOUT_CYCLES);
			errors++;
		end else begin
			// Drain the pipeline
			repeat (8) @(negedge clk);
			if (store_count != STORES_EXPECTED) begin
				$display("CHECK FAILED t=%0t store_count got %0d expected %0d",
					$time, store_count, STORES_EXPECTED);
				errors++;
			end
		end

		assert_fails = int'(dut0.checks.fail_count);
		$display("Errors: testbench %0d, assertions %0d, lane stores %0d",
			errors, assert_fails, store_count);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+design
design/vx_isa_pkg.sv
design/vx_pipe_pkg.sv
design/vx_pipe_reg.sv
design/vx_fetch.sv
design/vx_front_end.sv
design/vx_forwarding.sv
design/vx_execute.sv
design/vx_csr_handler.sv
design/vx_core.sv
tests/vx_core_assert.sv
tests/tb_vx_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vx_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
